// File: Bender.yml
package:
  name: mem_ctrl

sources:
  - rtl/mem_ctrl_pkg.sv
  - rtl/mem_bus_pkg.sv
  - rtl/mem_apb_port.sv
  - rtl/mem_sequencer.sv
  - rtl/mem_cmd_issue.sv
  - rtl/mem_ctrl_top.sv
  - target: test
    files:
      - bench/app_mem_model.sv
      - bench/tb_mem_ctrl.sv

// File: bench/app_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module app_mem_model
(
	input wire clk,
	input wire rst,
	input wire force_rdy,
	input wire mem_bus_pkg::app_cmd_t app_cmd,
	output logic app_rdy,
	input wire mem_bus_pkg::app_wdf_t app_wdf,
	output logic app_wdf_rdy,
	output mem_bus_pkg::app_rd_t app_rd
);
	import mem_ctrl_pkg::*;
	import mem_bus_pkg::*;

	localparam int MEM_STRIPS = 256;
	localparam int LOG_DEPTH = 128;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// Strip storage indexed by address bits 11:4
	strip_t mem [MEM_STRIPS];
	// Write beats wait here until their command arrives
	strip_t wr_fifo [$];
	app_addr_t rd_addr_q [$];
	int rd_due_q [$];
	logic [31:0] lfsr;
	int cycle;
	int last_due;
	// Every accepted command, read by the testbench after each operation
	app_addr_t log_addr [LOG_DEPTH];
	app_cmd_e log_cmd [LOG_DEPTH];
	int log_cnt;

	// One shift of a right shifting Galois LFSR, the new bit is taken from bit 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
	endfunction

	initial
	begin
		lfsr = 32'hd05d;
		cycle = 0;
		last_due = 0;
		log_cnt = 0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd = '0;
		// Fill pattern carries the strip index so stale reads stand out
		for (int i = 0; i < MEM_STRIPS; i++)
			mem[i] = {4{{24'h3c5a96, 8'(i)}}};
	end

	// ========================================
	// Memory side, stepped on falling edges
	// ========================================

	// The DUT outputs seen here stay put until the next rising edge, so an accept is
	// known as soon as the ready for that edge is chosen
	always @(negedge clk)
	begin : model_step
		int due;
		app_addr_t rd_addr;
		logic [1:0] dbits;
		if (rst)
		begin
			app_rdy = 1'b0;
			app_wdf_rdy = 1'b0;
			app_rd = '0;
			wr_fifo.delete();
			rd_addr_q.delete();
			rd_due_q.delete();
		end
		else
		begin
			cycle++;
			// Oldest pending read goes out once its delay has run down
			if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle)
			begin
				rd_addr = rd_addr_q.pop_front();
				due = rd_due_q.pop_front();
				app_rd.rd_valid = 1'b1;
				app_rd.rd_end = 1'b1;
				app_rd.rd_data = mem[rd_addr[11:4]];
			end
			else
				app_rd = '0;
			if (force_rdy)
			begin
				app_rdy = 1'b1;
				app_wdf_rdy = 1'b1;
			end
			else
			begin
				lfsr = lfsr_next(lfsr);
				app_rdy = lfsr[0];
				lfsr = lfsr_next(lfsr);
				app_wdf_rdy = lfsr[0];
			end
			if (app_wdf.wren && app_wdf_rdy)
				wr_fifo.push_back(app_wdf.data);
			if (app_cmd.en && app_rdy)
			begin
				if (log_cnt < LOG_DEPTH)
				begin
					log_addr[log_cnt] = app_cmd.addr;
					log_cmd[log_cnt] = app_cmd.cmd;
				end
				log_cnt++;
				if (app_cmd.cmd == CMD_WRITE)
				begin
					if (wr_fifo.size() > 0)
						mem[app_cmd.addr[11:4]] = wr_fifo.pop_front();
				end
				else
				begin
					// Return delay of 2 to 5 cycles, never overtaking an earlier read
					lfsr = lfsr_next(lfsr);
					dbits[0] = lfsr[0];
					lfsr = lfsr_next(lfsr);
					dbits[1] = lfsr[0];
					due = cycle + 2 + int'(dbits);
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					rd_addr_q.push_back(app_cmd.addr);
					rd_due_q.push_back(due);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl;
	import mem_ctrl_pkg::*;
	import mem_bus_pkg::*;

	// One row drives a write and a read of the same line
	typedef struct packed
	{
		app_addr_t addr;
		strip_cnt_t cnt;
		word_t seed;
		logic fast;
		logic [2:0] exp_cmds;
	} test_row_t;

	localparam int NUM_ROWS = 6;
	localparam int CYCLES_PER_ROW = 400;
	localparam int ADDR_STEP = 16;

	logic clk;
	logic rst;
	logic force_rdy;
	apb_req_t apb_in;
	apb_rsp_t apb_out;
	app_cmd_t app_cmd;
	logic app_rdy;
	app_wdf_t app_wdf;
	logic app_wdf_rdy;
	app_rd_t app_rd;
	test_row_t test_table [NUM_ROWS];
	int mismatch_cnt;
	int other_cnt;

	mem_ctrl_top uut
	(
		.clk(clk),
		.rst(rst),
		.apb_in(apb_in),
		.apb_out(apb_out),
		.app_cmd(app_cmd),
		.app_rdy(app_rdy),
		.app_wdf(app_wdf),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd(app_rd)
	);

	app_mem_model mem_model
	(
		.clk(clk),
		.rst(rst),
		.force_rdy(force_rdy),
		.app_cmd(app_cmd),
		.app_rdy(app_rdy),
		.app_wdf(app_wdf),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd(app_rd)
	);

	// 8 ns clock period
	initial
		clk = 1'b0;
	always #4 clk = ~clk;

	// ========================================
	// Helpers
	// ========================================
	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		mismatch_cnt++;
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		other_cnt++;
	endtask

	// Line words are made from the row seed so each row carries its own data
	function automatic word_t expected_word(input word_t seed, input int k);
		return seed ^ (word_t'(k) * 32'h9e37_79b9);
	endfunction

	// Setup on one falling edge, access on the next, then back to idle
	task automatic apb_write(input apb_addr_t addr, input word_t data);
		@(negedge clk);
		apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(negedge clk);
		apb_in.penable = 1'b1;
		@(negedge clk);
		apb_in = '0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
		@(negedge clk);
		apb_in = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(negedge clk);
		apb_in.penable = 1'b1;
		// Response settles well before the rising edge of the access cycle
		#1;
		data = apb_out.prdata;
		err = apb_out.pslverr;
		// No wait states, so every access completes at once
		if (apb_out.pready !== 1'b1)
			report_mismatch("pready", word_t'(apb_out.pready), 32'h1);
		@(negedge clk);
		apb_in = '0;
	endtask

	// Poll STATUS until the done bit comes up
	task automatic wait_done();
		word_t st;
		logic err;
		st = '0;
		while (!st[1])
			apb_read(REG_STATUS, st, err);
	endtask

	// Commands accepted since base must walk the line strip by strip
	task automatic check_log(input int base, input test_row_t row, input app_cmd_e exp_cmd);
		app_addr_t exp_addr;
		if (mem_model.log_cnt - base != int'(row.exp_cmds))
			report_failure($sformatf("%0d commands accepted where %0d were expected",
				mem_model.log_cnt - base, row.exp_cmds));
		for (int i = 0; i < int'(row.exp_cmds); i++)
		begin
			exp_addr = row.addr + app_addr_t'(i * ADDR_STEP);
			if (mem_model.log_addr[base + i] !== exp_addr)
				report_mismatch("app_cmd.addr", word_t'(mem_model.log_addr[base + i]),
					word_t'(exp_addr));
			if (mem_model.log_cmd[base + i] !== exp_cmd)
				report_mismatch("app_cmd.cmd", word_t'(mem_model.log_cmd[base + i]),
					word_t'(exp_cmd));
		end
	endtask

	// Each strip is a single beat with every byte written
	always @(negedge clk)
	begin
		if (!rst && app_wdf.wren === 1'b1 && app_wdf.wdf_end !== 1'b1)
			report_mismatch("app_wdf.wdf_end", word_t'(app_wdf.wdf_end), 32'h1);
		if (!rst && app_wdf.mask !== 16'h0)
			report_mismatch("app_wdf.mask", word_t'(app_wdf.mask), 32'h0);
	end

	// Write the line, clear the buffer, read the line back and compare
	task automatic run_row(input test_row_t row);
		int n_words;
		int base;
		word_t rdata;
		logic err;
		n_words = int'(row.exp_cmds) * 4;
		@(posedge clk);
		force_rdy = row.fast;
		apb_write(REG_ADDR, word_t'(row.addr));
		for (int k = 0; k < n_words; k++)
			apb_write(REG_LINE + apb_addr_t'(4 * k), expected_word(row.seed, k));
		base = mem_model.log_cnt;
		apb_write(REG_CTRL, word_t'({row.cnt, 4'b0001}));
		// This go lands while busy, so the running write must not change
		apb_write(REG_CTRL, word_t'({~row.cnt, 4'b0011}));
		wait_done();
		apb_read(REG_STATUS, rdata, err);
		if (rdata !== 32'h6)
			report_mismatch("STATUS", rdata, 32'h6);
		check_log(base, row, CMD_WRITE);
		for (int k = 0; k < 16; k++)
			apb_write(REG_LINE + apb_addr_t'(4 * k), '0);
		base = mem_model.log_cnt;
		apb_write(REG_CTRL, word_t'({row.cnt, 4'b0011}));
		wait_done();
		// A new go clears the refused-go flag
		apb_read(REG_STATUS, rdata, err);
		if (rdata !== 32'h2)
			report_mismatch("STATUS", rdata, 32'h2);
		check_log(base, row, CMD_READ);
		for (int k = 0; k < n_words; k++)
		begin
			apb_read(REG_LINE + apb_addr_t'(4 * k), rdata, err);
			if (rdata !== expected_word(row.seed, k))
				report_mismatch($sformatf("line word %0d", k), rdata, expected_word(row.seed, k));
			if (err !== 1'b0)
				report_failure("APB error on a line buffer read");
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		word_t rdata;
		logic err;
		mismatch_cnt = 0;
		other_cnt = 0;
		rst = 1'b1;
		force_rdy = 1'b1;
		apb_in = '0;
		test_table[0] = '{addr: 28'h000_0100, cnt: 2'd3, seed: 32'h1357_9bdf, fast: 1'b1, exp_cmds: 3'd4};
		test_table[1] = '{addr: 28'h000_0240, cnt: 2'd0, seed: 32'h2468_ace0, fast: 1'b0, exp_cmds: 3'd1};
		test_table[2] = '{addr: 28'h000_0380, cnt: 2'd1, seed: 32'h0f1e_2d3c, fast: 1'b0, exp_cmds: 3'd2};
		test_table[3] = '{addr: 28'h123_4560, cnt: 2'd2, seed: 32'h5a5a_0f0f, fast: 1'b0, exp_cmds: 3'd3};
		test_table[4] = '{addr: 28'h00f_ffc0, cnt: 2'd3, seed: 32'h7777_1111, fast: 1'b0, exp_cmds: 3'd4};
		test_table[5] = '{addr: 28'h000_0800, cnt: 2'd3, seed: 32'h8000_0001, fast: 1'b1, exp_cmds: 3'd4};
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Quiet outputs and a clean STATUS before any access
		if (app_cmd.en !== 1'b0)
			report_mismatch("app_cmd.en", word_t'(app_cmd.en), 32'h0);
		if (app_wdf.wren !== 1'b0)
			report_mismatch("app_wdf.wren", word_t'(app_wdf.wren), 32'h0);
		apb_read(REG_STATUS, rdata, err);
		if (rdata !== 32'h0)
			report_mismatch("STATUS", rdata, 32'h0);
		// Offset 0x20 is unmapped
		apb_read(8'h20, rdata, err);
		if (err !== 1'b1)
			report_mismatch("pslverr", word_t'(err), 32'h1);
		if (rdata !== 32'h0)
			report_mismatch("prdata", rdata, 32'h0);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(test_table[r]);
		$display("Summary: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog sized from the number of table rows
	initial
	begin
		repeat (NUM_ROWS * CYCLES_PER_ROW) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", NUM_ROWS * CYCLES_PER_ROW);
		$display("Summary: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
rtl/mem_ctrl_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_apb_port.sv
rtl/mem_sequencer.sv
rtl/mem_cmd_issue.sv
rtl/mem_ctrl_top.sv
bench/app_mem_model.sv
bench/tb_mem_ctrl.sv

// File: rtl/mem_apb_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_apb_port
(
	input wire clk,
	input wire rst,
	input wire mem_bus_pkg::apb_req_t apb_in,
	output mem_bus_pkg::apb_rsp_t apb_out,
	output mem_bus_pkg::line_req_t line_req,
	input wire finish,
	input wire mem_ctrl_pkg::strip_cnt_t strip_idx,
	output mem_ctrl_pkg::strip_t strip_rd,
	input wire mem_bus_pkg::line_mem_t line_wr
);
	import mem_ctrl_pkg::*;
	import mem_bus_pkg::*;

	localparam int WORD_BITS = $bits(word_t);

	word_t line_mem [LINE_WORDS];
	app_addr_t addr_q;
	logic read_q;
	strip_cnt_t cnt_q;
	logic start_q;
	logic busy;
	logic done;
	logic ign_go;
	logic access;
	logic wr_access;
	logic sel_addr;
	logic sel_ctrl;
	logic sel_status;
	logic sel_line;
	logic go;
	line_idx_t host_widx;

	// ========================================
	// Address decode
	// ========================================

	// The access phase is the second cycle of every transfer
	assign access = apb_in.psel && apb_in.penable;
	assign wr_access = access && apb_in.pwrite;
	assign sel_addr = apb_in.paddr == REG_ADDR;
	assign sel_ctrl = apb_in.paddr == REG_CTRL;
	assign sel_status = apb_in.paddr == REG_STATUS;
	// Only word aligned offsets inside the window hit the line buffer
	assign sel_line = apb_in.paddr >= REG_LINE && apb_in.paddr <= REG_LINE_LAST
		&& apb_in.paddr[1:0] == 2'b00;
	assign host_widx = apb_in.paddr[5:2];
	assign go = wr_access && sel_ctrl && apb_in.pwdata[CTRL_GO_BIT];

	// No wait states, so pready stays high and read data is ready in the access cycle
	always_comb
	begin
		apb_out.prdata = '0;
		apb_out.pready = 1'b1;
		apb_out.pslverr = 1'b0;
		if (sel_addr)
			apb_out.prdata = word_t'(addr_q);
		else if (sel_ctrl)
			apb_out.prdata = word_t'({cnt_q, 2'b00, read_q, 1'b0});
		else if (sel_status)
			apb_out.prdata = word_t'({ign_go, done, busy});
		else if (sel_line)
			apb_out.prdata = line_mem[host_widx];
		else
			apb_out.pslverr = access;
	end

	// ========================================
	// Control and status
	// ========================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			addr_q <= '0;
			read_q <= 1'b0;
			cnt_q <= '0;
			start_q <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			ign_go <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			if (finish)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			// Setup registers stay frozen while an operation runs so the sequencer sees them stable
			if (wr_access && !busy)
			begin
				if (sel_addr)
					addr_q <= apb_in.pwdata[$bits(app_addr_t)-1:0];
				if (sel_ctrl)
				begin
					read_q <= apb_in.pwdata[CTRL_READ_BIT];
					cnt_q <= apb_in.pwdata[CTRL_CNT_LSB +: $bits(strip_cnt_t)];
				end
			end
			// A go during an operation is dropped and only leaves a sticky flag behind
			if (go && busy)
				ign_go <= 1'b1;
			else if (go)
			begin
				start_q <= 1'b1;
				busy <= 1'b1;
				done <= 1'b0;
				ign_go <= 1'b0;
			end
		end
	end

	assign line_req = '{start: start_q, read: read_q, addr: addr_q, num_strips: cnt_q};

	// ========================================
	// Line buffer
	// ========================================

	// The sequencer owns the buffer while busy, the host only while idle
	always_ff @(posedge clk)
	begin
		if (line_wr.we)
		begin
			for (int k = 0; k < WORDS_PER_STRIP; k++)
				line_mem[line_wr.idx + line_idx_t'(k)] <= line_wr.data[k*WORD_BITS +: WORD_BITS];
		end
		else if (wr_access && sel_line && !busy)
			line_mem[host_widx] <= apb_in.pwdata;
	end

	// Word zero of a strip sits in its low bits
	always_comb
	begin
		for (int k = 0; k < WORDS_PER_STRIP; k++)
			strip_rd[k*WORD_BITS +: WORD_BITS] = line_mem[{strip_idx, 2'(k)}];
	end

endmodule

`default_nettype wire

// File: rtl/mem_bus_pkg.sv
`default_nettype none

// Bundles that travel between the host, the controller blocks and the app interface
package mem_bus_pkg;

	// APB request as the host drives it
	typedef struct packed
	{
		logic psel;
		logic penable;
		logic pwrite;
		mem_ctrl_pkg::apb_addr_t paddr;
		mem_ctrl_pkg::word_t pwdata;
	} apb_req_t;

	// APB response
	typedef struct packed
	{
		mem_ctrl_pkg::word_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// App command channel, accepted on en with rdy
	typedef struct packed
	{
		logic en;
		mem_ctrl_pkg::app_cmd_e cmd;
		mem_ctrl_pkg::app_addr_t addr;
	} app_cmd_t;

	// App write data channel, one beat per strip
	typedef struct packed
	{
		logic wren;
		logic wdf_end;
		mem_ctrl_pkg::strip_t data;
		logic [15:0] mask;
	} app_wdf_t;

	// App read return, in command order with no back-pressure
	typedef struct packed
	{
		logic rd_valid;
		logic rd_end;
		mem_ctrl_pkg::strip_t rd_data;
	} app_rd_t;

	// Line operation request from the register block to the sequencer
	typedef struct packed
	{
		logic start;
		logic read;
		mem_ctrl_pkg::app_addr_t addr;
		mem_ctrl_pkg::strip_cnt_t num_strips;
	} line_req_t;

	// Strip write port into the line buffer
	typedef struct packed
	{
		logic we;
		mem_ctrl_pkg::line_idx_t idx;
		mem_ctrl_pkg::strip_t data;
	} line_mem_t;

endpackage

`default_nettype wire

// File: rtl/mem_cmd_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mem_cmd_issue
(
	input wire clk,
	input wire rst,
	input wire mem_ctrl_pkg::seq_state_e state,
	input wire rdy,
	input wire mem_ctrl_pkg::strip_cnt_t num_strips,
	output logic en,
	output logic accepted,
	output mem_ctrl_pkg::strip_cnt_t strip_cnt
);
	import mem_ctrl_pkg::*;

	logic last_strip;

	// The memory takes a command in any cycle with both en and rdy high
	assign accepted = en && rdy;
	assign last_strip = strip_cnt == num_strips;

	// ========================================
	// Command enable
	// ========================================

	// The enable follows the state by one cycle and is re-asserted until the command
	// is accepted, with the sequencer holding command and address steady meanwhile
	always_ff @(posedge clk)
	begin
		if (rst)
			en <= 1'b0;
		else
		begin
			en <= 1'b0;
			if (state == WRITE_DATA1)
				en <= 1'b1;
			else if (state == WRITE_DATA2 && !accepted)
				en <= 1'b1;
			else if (state == READ_DATA0)
				en <= 1'b1;
			// Reads keep the enable up across strips until the final one is taken
			else if (state == READ_DATA1 && !(accepted && last_strip))
				en <= 1'b1;
		end
	end

	// Strip counter, which also selects the command address and the write strip
	always_ff @(posedge clk)
	begin
		if (rst)
			strip_cnt <= '0;
		else if (state == IDLE)
			strip_cnt <= '0;
		// Writes step once per finished strip
		else if (state == WRITE_NEXT && !last_strip)
			strip_cnt <= strip_cnt + strip_cnt_t'(1);
		// Reads step on each acceptance so the next address is ready at once
		else if (state == READ_DATA1 && accepted && !last_strip)
			strip_cnt <= strip_cnt + strip_cnt_t'(1);
	end

endmodule

`default_nettype wire

// File: rtl/mem_ctrl_pkg.sv
`default_nettype none

// Controller-wide constants, width types and the sequencer state encoding
package mem_ctrl_pkg;

	// ========================================
	// Width types
	// ========================================

	// Byte address on the app interface
	typedef logic [27:0] app_addr_t;
	// One app data beat, which is one strip of the line
	typedef logic [127:0] strip_t;
	// One APB data word
	typedef logic [31:0] word_t;
	// Strip index, also used for the strip count stored as count minus one
	typedef logic [1:0] strip_cnt_t;
	// Word index into the line buffer
	typedef logic [3:0] line_idx_t;
	// APB register offset
	typedef logic [7:0] apb_addr_t;

	// Address distance between consecutive strips, in bytes
	localparam int STRIP_ADDR_STEP = 16;
	localparam int WORDS_PER_STRIP = 4;
	localparam int LINE_WORDS = 16;

	// ========================================
	// Register map
	// ========================================
	localparam apb_addr_t REG_ADDR = 8'h00;
	localparam apb_addr_t REG_CTRL = 8'h04;
	localparam apb_addr_t REG_STATUS = 8'h08;
	// The line buffer occupies sixteen words from here up to the last offset
	localparam apb_addr_t REG_LINE = 8'h40;
	localparam apb_addr_t REG_LINE_LAST = 8'h7C;

	// CTRL bit positions
	localparam int CTRL_GO_BIT = 0;
	localparam int CTRL_READ_BIT = 1;
	localparam int CTRL_CNT_LSB = 4;

	// Command codes as the memory controller core expects them
	typedef enum logic [2:0] {CMD_WRITE = 3'd0, CMD_READ = 3'd1} app_cmd_e;

	typedef enum logic [3:0] {IDLE, WRITE_DATA0, WRITE_DATA1, WRITE_DATA2, WRITE_NEXT,
		READ_DATA0, READ_DATA1, READ_WAIT, DONE} seq_state_e;

endpackage

`default_nettype wire

// File: rtl/mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top
(
	input wire clk,
	input wire rst,
	input wire mem_bus_pkg::apb_req_t apb_in,
	output mem_bus_pkg::apb_rsp_t apb_out,
	output mem_bus_pkg::app_cmd_t app_cmd,
	input wire app_rdy,
	output mem_bus_pkg::app_wdf_t app_wdf,
	input wire app_wdf_rdy,
	input wire mem_bus_pkg::app_rd_t app_rd
);
	import mem_ctrl_pkg::*;
	import mem_bus_pkg::*;

	line_req_t line_req;
	logic finish;
	strip_cnt_t strip_idx;
	strip_t strip_rd;
	line_mem_t line_wr;
	seq_state_e state;
	strip_cnt_t strip_cnt;
	logic accepted;
	logic cmd_en;
	app_cmd_t cmd_body;

	// Host registers and the line buffer
	mem_apb_port u_apb_port
	(
		.clk(clk),
		.rst(rst),
		.apb_in(apb_in),
		.apb_out(apb_out),
		.line_req(line_req),
		.finish(finish),
		.strip_idx(strip_idx),
		.strip_rd(strip_rd),
		.line_wr(line_wr)
	);

	mem_sequencer u_sequencer
	(
		.clk(clk),
		.rst(rst),
		.line_req(line_req),
		.finish(finish),
		.strip_idx(strip_idx),
		.strip_rd(strip_rd),
		.line_wr(line_wr),
		.state(state),
		.strip_cnt(strip_cnt),
		.accepted(accepted),
		.cmd_out(cmd_body),
		.wdf(app_wdf),
		.wdf_rdy(app_wdf_rdy),
		.rd(app_rd)
	);

	// The strip count is stable in the register block for the whole operation
	mem_cmd_issue u_cmd_issue
	(
		.clk(clk),
		.rst(rst),
		.state(state),
		.rdy(app_rdy),
		.num_strips(line_req.num_strips),
		.en(cmd_en),
		.accepted(accepted),
		.strip_cnt(strip_cnt)
	);

	// The enable joins the command code and address here
	assign app_cmd = '{en: cmd_en, cmd: cmd_body.cmd, addr: cmd_body.addr};

endmodule

`default_nettype wire

// File: rtl/mem_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer
(
	input wire clk,
	input wire rst,
	input wire mem_bus_pkg::line_req_t line_req,
	output logic finish,
	output mem_ctrl_pkg::strip_cnt_t strip_idx,
	input wire mem_ctrl_pkg::strip_t strip_rd,
	output mem_bus_pkg::line_mem_t line_wr,
	output mem_ctrl_pkg::seq_state_e state,
	input wire mem_ctrl_pkg::strip_cnt_t strip_cnt,
	input wire accepted,
	output mem_bus_pkg::app_cmd_t cmd_out,
	output mem_bus_pkg::app_wdf_t wdf,
	input wire wdf_rdy,
	input wire mem_bus_pkg::app_rd_t rd
);
	import mem_ctrl_pkg::*;
	import mem_bus_pkg::*;

	// Number of strips already returned by the memory during a read
	strip_cnt_t rd_cnt;
	logic last_strip;
	logic last_rd;
	logic rd_take;

	// The strip counter comes from the issue block and only moves on acceptance
	assign last_strip = strip_cnt == line_req.num_strips;
	// Returns can start arriving while later read commands are still being issued
	assign rd_take = rd.rd_valid && (state == READ_DATA1 || state == READ_WAIT);
	assign last_rd = rd_take && rd_cnt == line_req.num_strips;

	// ========================================
	// State machine
	// ========================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			rd_cnt <= '0;
		end
		else
		begin
			if (rd_take)
				rd_cnt <= rd_cnt + strip_cnt_t'(1);
			case (state)
				IDLE:
				begin
					rd_cnt <= '0;
					if (line_req.start)
						state <= line_req.read ? READ_DATA0 : WRITE_DATA0;
				end
				// Hold the data beat until the write FIFO takes it
				WRITE_DATA0:
					if (wdf_rdy)
						state <= WRITE_DATA1;
				// The command enable rises on leaving this state
				WRITE_DATA1:
					state <= WRITE_DATA2;
				// Wait here while the command is retried
				WRITE_DATA2:
					if (accepted)
						state <= WRITE_NEXT;
				WRITE_NEXT:
					state <= last_strip ? DONE : WRITE_DATA0;
				READ_DATA0:
					state <= READ_DATA1;
				// Commands for all strips go out back to back from here
				READ_DATA1:
					if (accepted && last_strip)
						state <= READ_WAIT;
				READ_WAIT:
					if (last_rd)
						state <= DONE;
				DONE:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	assign finish = state == DONE;
	assign strip_idx = strip_cnt;

	// ========================================
	// App channels and line buffer writes
	// ========================================
	always_comb
	begin
		// The issue block supplies the enable, so only code and address come from here
		cmd_out.en = 1'b0;
		cmd_out.cmd = line_req.read ? CMD_READ : CMD_WRITE;
		cmd_out.addr = line_req.addr + app_addr_t'(strip_cnt) * app_addr_t'(STRIP_ADDR_STEP);

		// A strip is a single beat, so every beat is also the last one
		wdf.wren = state == WRITE_DATA0;
		wdf.wdf_end = state == WRITE_DATA0;
		wdf.data = strip_rd;
		wdf.mask = '0;

		// Returned strips land in the buffer in command order
		line_wr.we = rd_take;
		line_wr.idx = {rd_cnt, 2'b00};
		line_wr.data = rd.rd_data;
	end

endmodule

`default_nettype wire
